// ==== logic/memGeomPkg.sv ====
`default_nettype none

package memGeomPkg;

	// Bytes in one memory word
	localparam int byteCount = 4;

	// 64 words
	localparam int addressSize = 6;

	localparam int wordSize = 8 * byteCount;

endpackage

`default_nettype wire

// ==== logic/scratchCmdPkg.sv ====
`default_nettype none

package scratchCmdPkg;

	// Command opcodes as sent by the agent
	typedef enum logic [1:0] {
		opWrite    = 2'd0,
		opRead     = 2'd1,
		opCopy     = 2'd2,
		// Raises cmdError only
		opReserved = 2'd3
	} opcodeT;

endpackage

`default_nettype wire

// ==== logic/cmdDecode.sv ====
`default_nettype none
`timescale 1ns/10ps

module cmdDecode (
	input  logic                                clk0,
	input  logic                                rstN,
	input  logic                                cmdStrobe,
	input  scratchCmdPkg::opcodeT               cmdOpcode,
	input  logic [memGeomPkg::addressSize-1:0]  cmdAddress,
	input  logic [memGeomPkg::addressSize-1:0]  cmdSourceAddress,
	input  logic [memGeomPkg::wordSize-1:0]     cmdData,
	input  logic [memGeomPkg::byteCount-1:0]    cmdMask,
	input  logic                                busy,
	output logic                                decValid,
	output scratchCmdPkg::opcodeT               decOpcode,
	output logic [memGeomPkg::addressSize-1:0]  decAddress,
	output logic [memGeomPkg::addressSize-1:0]  decSourceAddress,
	output logic [memGeomPkg::wordSize-1:0]     decData,
	output logic [memGeomPkg::byteCount-1:0]    decMask,
	output logic                                cmdError
);
	import scratchCmdPkg::*;

	logic accept;

	// Strobes seen while busy are simply lost
	assign accept = cmdStrobe && !busy;

	always_ff @(posedge clk0 or negedge rstN) begin
		if (!rstN) begin
			decValid <= 1'b0;
			cmdError <= 1'b0;
		end else begin
			decValid <= accept && (cmdOpcode != opReserved);
			// One-cycle pulse, no work reaches execute
			cmdError <= accept && (cmdOpcode == opReserved);
		end
	end

	// Command fields, meaningful only while decValid is high
	always_ff @(posedge clk0) begin
		if (accept) begin
			decOpcode <= cmdOpcode;
			decAddress <= cmdAddress;
			decSourceAddress <= cmdSourceAddress;
			decData <= cmdData;
			decMask <= cmdMask;
		end
	end

endmodule

`default_nettype wire

// ==== logic/scratchExecute.sv ====
`default_nettype none
`timescale 1ns/10ps

module scratchExecute (
	input  logic                                clk0,
	input  logic                                rstN,
	input  logic                                decValid,
	input  scratchCmdPkg::opcodeT               decOpcode,
	input  logic [memGeomPkg::addressSize-1:0]  decAddress,
	input  logic [memGeomPkg::addressSize-1:0]  decSourceAddress,
	input  logic [memGeomPkg::wordSize-1:0]     decData,
	input  logic [memGeomPkg::byteCount-1:0]    decMask,
	input  logic [memGeomPkg::wordSize-1:0]     secondaryDataRead,
	output logic                                busy,
	output logic                                primarySelect,
	output logic                                primaryWriteEnable,
	output logic [memGeomPkg::byteCount-1:0]    primaryWriteMask,
	output logic [memGeomPkg::addressSize-1:0]  primaryAddress,
	output logic [memGeomPkg::wordSize-1:0]     primaryDataWrite,
	output logic                                secondarySelect,
	output logic [memGeomPkg::addressSize-1:0]  secondaryAddress,
	output logic                                readIssued
);
	import memGeomPkg::*;
	import scratchCmdPkg::*;

	logic                   copyStart;
	logic                   copyPending;
	logic [addressSize-1:0] copyDest;

	// First COPY step, source read on the secondary port
	assign copyStart = decValid && (decOpcode == opCopy);
	assign secondarySelect = copyStart;
	assign secondaryAddress = decSourceAddress;

	// Blocks the strobe sampled at the edge that opens the copy write
	assign busy = copyStart;

	assign readIssued = decValid && (decOpcode == opRead);

	always_ff @(posedge clk0 or negedge rstN) begin
		if (!rstN) begin
			copyPending <= 1'b0;
		end else begin
			copyPending <= copyStart;
		end
	end

	always_ff @(posedge clk0) begin
		if (copyStart) begin
			copyDest <= decAddress;
		end
	end

	// Primary port, the copy write has priority
	always_comb begin
		primarySelect = 1'b0;
		primaryWriteEnable = 1'b0;
		primaryWriteMask = '0;
		primaryAddress = decAddress;
		primaryDataWrite = decData;
		if (copyPending) begin
			// Source word arrived on the falling edge
			primarySelect = 1'b1;
			primaryWriteEnable = 1'b1;
			primaryWriteMask = '1;
			primaryAddress = copyDest;
			primaryDataWrite = secondaryDataRead;
		end else if (decValid) begin
			case (decOpcode)
				opWrite: begin
					primarySelect = 1'b1;
					primaryWriteEnable = 1'b1;
					primaryWriteMask = decMask;
				end
				opRead: begin
					primarySelect = 1'b1;
				end
				default: begin
					primarySelect = 1'b0;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== logic/dualPortSram.sv ====
`default_nettype none
`timescale 1ns/10ps

module dualPortSram #(
	parameter int byteCount = memGeomPkg::byteCount,
	parameter int addressSize = memGeomPkg::addressSize
) (
	input  logic                     clk0,
	input  logic                     rstN,
	input  logic                     primarySelect,
	input  logic                     primaryWriteEnable,
	input  logic [byteCount-1:0]     primaryWriteMask,
	input  logic [addressSize-1:0]   primaryAddress,
	input  logic [8*byteCount-1:0]   primaryDataWrite,
	output logic [8*byteCount-1:0]   primaryDataRead,
	input  logic                     secondarySelect,
	input  logic [addressSize-1:0]   secondaryAddress,
	output logic [8*byteCount-1:0]   secondaryDataRead
);
	localparam int wordSize = 8 * byteCount;
	localparam int depth = 1 << addressSize;

	logic [wordSize-1:0] memory [depth];

	// Input register stage, read/write port
	logic                   primarySelectReg;
	logic                   primaryWriteEnableReg;
	logic [byteCount-1:0]   primaryWriteMaskReg;
	logic [addressSize-1:0] primaryAddressReg;
	logic [wordSize-1:0]    primaryDataWriteReg;

	// Input register stage, read-only port
	logic                   secondarySelectReg;
	logic [addressSize-1:0] secondaryAddressReg;

	always_ff @(posedge clk0 or negedge rstN) begin
		if (!rstN) begin
			primarySelectReg <= 1'b0;
			secondarySelectReg <= 1'b0;
		end else begin
			primarySelectReg <= primarySelect;
			secondarySelectReg <= secondarySelect;
		end
	end

	always_ff @(posedge clk0) begin
		primaryWriteEnableReg <= primaryWriteEnable;
		primaryWriteMaskReg <= primaryWriteMask;
		primaryAddressReg <= primaryAddress;
		primaryDataWriteReg <= primaryDataWrite;
		secondaryAddressReg <= secondaryAddress;
	end

	// Byte-masked write, half a cycle after the inputs are taken
	always_ff @(negedge clk0) begin
		if (primarySelectReg && primaryWriteEnableReg) begin
			for (int byteIndex = 0; byteIndex < byteCount; byteIndex++) begin
				if (primaryWriteMaskReg[byteIndex]) begin
					memory[primaryAddressReg][byteIndex*8 +: 8] <=
						primaryDataWriteReg[byteIndex*8 +: 8];
				end
			end
		end
	end

	// Read outputs keep their last word between accesses
	always_ff @(negedge clk0) begin
		if (primarySelectReg && !primaryWriteEnableReg) begin
			primaryDataRead <= memory[primaryAddressReg];
		end
		if (secondarySelectReg) begin
			secondaryDataRead <= memory[secondaryAddressReg];
		end
	end

endmodule

`default_nettype wire

// ==== logic/readResult.sv ====
`default_nettype none
`timescale 1ns/10ps

module readResult (
	input  logic                             clk0,
	input  logic                             rstN,
	input  logic                             readIssued,
	input  logic [memGeomPkg::wordSize-1:0]  primaryDataRead,
	output logic                             rspValid,
	output logic [memGeomPkg::wordSize-1:0]  rspData
);
	// Read registered in the SRAM, data due at the next rising edge
	logic readInFlight;

	always_ff @(posedge clk0 or negedge rstN) begin
		if (!rstN) begin
			readInFlight <= 1'b0;
			rspValid <= 1'b0;
		end else begin
			readInFlight <= readIssued;
			rspValid <= readInFlight;
		end
	end

	// Holds the last response word
	always_ff @(posedge clk0) begin
		if (readInFlight) begin
			rspData <= primaryDataRead;
		end
	end

endmodule

`default_nettype wire

// ==== logic/scratchpadTop.sv ====
`default_nettype none
`timescale 1ns/10ps

module scratchpadTop (
	input  logic                                clk0,
	input  logic                                rstN,
	input  logic                                cmdStrobe,
	input  scratchCmdPkg::opcodeT               cmdOpcode,
	input  logic [memGeomPkg::addressSize-1:0]  cmdAddress,
	input  logic [memGeomPkg::addressSize-1:0]  cmdSourceAddress,
	input  logic [memGeomPkg::wordSize-1:0]     cmdData,
	input  logic [memGeomPkg::byteCount-1:0]    cmdMask,
	output logic                                busy,
	output logic                                cmdError,
	output logic                                rspValid,
	output logic [memGeomPkg::wordSize-1:0]     rspData
);
	// Decoded command
	logic                               decValid;
	scratchCmdPkg::opcodeT              decOpcode;
	logic [memGeomPkg::addressSize-1:0] decAddress;
	logic [memGeomPkg::addressSize-1:0] decSourceAddress;
	logic [memGeomPkg::wordSize-1:0]    decData;
	logic [memGeomPkg::byteCount-1:0]   decMask;

	// SRAM ports
	logic                               primarySelect;
	logic                               primaryWriteEnable;
	logic [memGeomPkg::byteCount-1:0]   primaryWriteMask;
	logic [memGeomPkg::addressSize-1:0] primaryAddress;
	logic [memGeomPkg::wordSize-1:0]    primaryDataWrite;
	logic [memGeomPkg::wordSize-1:0]    primaryDataRead;
	logic                               secondarySelect;
	logic [memGeomPkg::addressSize-1:0] secondaryAddress;
	logic [memGeomPkg::wordSize-1:0]    secondaryDataRead;

	logic                               readIssued;

	cmdDecode cmdDecode_inst (
		.clk0             (clk0),
		.rstN             (rstN),
		.cmdStrobe        (cmdStrobe),
		.cmdOpcode        (cmdOpcode),
		.cmdAddress       (cmdAddress),
		.cmdSourceAddress (cmdSourceAddress),
		.cmdData          (cmdData),
		.cmdMask          (cmdMask),
		.busy             (busy),
		.decValid         (decValid),
		.decOpcode        (decOpcode),
		.decAddress       (decAddress),
		.decSourceAddress (decSourceAddress),
		.decData          (decData),
		.decMask          (decMask),
		.cmdError         (cmdError)
	);

	scratchExecute scratchExecute_inst (
		.clk0               (clk0),
		.rstN               (rstN),
		.decValid           (decValid),
		.decOpcode          (decOpcode),
		.decAddress         (decAddress),
		.decSourceAddress   (decSourceAddress),
		.decData            (decData),
		.decMask            (decMask),
		.secondaryDataRead  (secondaryDataRead),
		.busy               (busy),
		.primarySelect      (primarySelect),
		.primaryWriteEnable (primaryWriteEnable),
		.primaryWriteMask   (primaryWriteMask),
		.primaryAddress     (primaryAddress),
		.primaryDataWrite   (primaryDataWrite),
		.secondarySelect    (secondarySelect),
		.secondaryAddress   (secondaryAddress),
		.readIssued         (readIssued)
	);

	dualPortSram #(
		.byteCount   (memGeomPkg::byteCount),
		.addressSize (memGeomPkg::addressSize)
	) dualPortSram_inst (
		.clk0               (clk0),
		.rstN               (rstN),
		.primarySelect      (primarySelect),
		.primaryWriteEnable (primaryWriteEnable),
		.primaryWriteMask   (primaryWriteMask),
		.primaryAddress     (primaryAddress),
		.primaryDataWrite   (primaryDataWrite),
		.primaryDataRead    (primaryDataRead),
		.secondarySelect    (secondarySelect),
		.secondaryAddress   (secondaryAddress),
		.secondaryDataRead  (secondaryDataRead)
	);

	readResult readResult_inst (
		.clk0            (clk0),
		.rstN            (rstN),
		.readIssued      (readIssued),
		.primaryDataRead (primaryDataRead),
		.rspValid        (rspValid),
		.rspData         (rspData)
	);

endmodule

`default_nettype wire

// ==== verif/scratchpad_props.sv ====
`default_nettype none
`timescale 1ns/10ps

module scratchpadProps (
	input  logic                  clk0,
	input  logic                  rstN,
	input  logic                  cmdStrobe,
	input  scratchCmdPkg::opcodeT cmdOpcode,
	input  logic                  busy,
	input  logic                  cmdError,
	input  logic                  rspValid
);
	import scratchCmdPkg::*;

	// Count of failed assertions
	int failCount = 0;

	// One response per accepted READ, in the cycle after its second edge
	rspAfterRead: assert property (@(posedge clk0) disable iff (!rstN)
		rspValid == $past(cmdStrobe && !busy && cmdOpcode == opRead, 3))
		else begin
			failCount++;
			$error("rspValid does not follow a READ accepted three edges before");
		end

	// Busy covers only the COPY read cycle
	busyPulse: assert property (@(posedge clk0) disable iff (!rstN) busy |=> !busy)
		else begin
			failCount++;
			$error("busy held for more than one cycle");
		end

	errorAfterStrobe: assert property (@(posedge clk0) disable iff (!rstN)
		$rose(cmdError) |-> $past(cmdStrobe))
		else begin
			failCount++;
			$error("cmdError raised without a strobe in the cycle before");
		end

endmodule

bind scratchpadTop scratchpadProps scratchpadProps_inst (
	.clk0      (clk0),
	.rstN      (rstN),
	.cmdStrobe (cmdStrobe),
	.cmdOpcode (cmdOpcode),
	.busy      (busy),
	.cmdError  (cmdError),
	.rspValid  (rspValid)
);

`default_nettype wire

// ==== verif/scratchpadTb.sv ====
`default_nettype none
`timescale 1ns/10ps

module scratchpadTb;
	import memGeomPkg::*;
	import scratchCmdPkg::*;

	localparam int clockPeriod = 40;
	localparam int resetCycles = 10;
	localparam int depth = 1 << addressSize;
	localparam int maskRounds = 40;
	localparam int copyRounds = 20;
	localparam int mixedCount = 60;
	localparam int busyRounds = 10;
	// Strobe and idle cycles over all tests
	localparam int commandBudget =
		2 * depth + 2 * maskRounds + 3 * copyRounds + mixedCount + 5 * busyRounds;
	localparam int watchdogCycles = resetCycles + 2 * commandBudget + 50;

	logic                   clk0 = 1'b0;
	logic                   rstN;
	logic                   cmdStrobe;
	opcodeT                 cmdOpcode;
	logic [addressSize-1:0] cmdAddress;
	logic [addressSize-1:0] cmdSourceAddress;
	logic [wordSize-1:0]    cmdData;
	logic [byteCount-1:0]   cmdMask;
	logic                   busy;
	logic                   cmdError;
	logic                   rspValid;
	logic [wordSize-1:0]    rspData;

	// Reference model and expected responses
	logic [wordSize-1:0] modelMemory [depth];
	bit                  modelWritten [depth];
	logic [wordSize-1:0] expData [$];
	bit                  expKnown [$];
	int                  expCycle [$];
	bit                  busyAt [int];
	bit                  errorAt [int];

	int          seed = 30;
	int          cycleCount = 0;
	int          errorCount = 0;
	logic [31:0] randomWord;
	logic [31:0] dataWord;

	scratchpadTop scratchpadTop_inst (
		.clk0             (clk0),
		.rstN             (rstN),
		.cmdStrobe        (cmdStrobe),
		.cmdOpcode        (cmdOpcode),
		.cmdAddress       (cmdAddress),
		.cmdSourceAddress (cmdSourceAddress),
		.cmdData          (cmdData),
		.cmdMask          (cmdMask),
		.busy             (busy),
		.cmdError         (cmdError),
		.rspValid         (rspValid),
		.rspData          (rspData)
	);

	always #(clockPeriod / 2) clk0 = ~clk0;

	// Edge number, equals n after the n-th rising edge
	always @(posedge clk0) begin
		cycleCount <= cycleCount + 1;
	end

	function automatic logic [31:0] nextRandom();
		return $random(seed);
	endfunction

	task automatic checkValue(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			errorCount++;
			$display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, actual, expected);
			$display("test failed");
			$fatal(1, "Stopping at the first mismatch");
		end
	endtask

	// Drives one strobe and applies it to the model if it will be accepted
	task automatic sendCommand(input opcodeT opcode, input logic [addressSize-1:0] address,
			input logic [addressSize-1:0] source, input logic [wordSize-1:0] data,
			input logic [byteCount-1:0] mask);
		int edgeIndex;
		@(negedge clk0);
		cmdStrobe = 1'b1;
		cmdOpcode = opcode;
		cmdAddress = address;
		cmdSourceAddress = source;
		cmdData = data;
		cmdMask = mask;
		edgeIndex = cycleCount + 1;
		// Dropped when a COPY was accepted on the edge before
		if (!busyAt.exists(cycleCount)) begin
			case (opcode)
				opWrite: begin
					for (int b = 0; b < byteCount; b++) begin
						if (mask[b]) begin
							modelMemory[address][b*8 +: 8] = data[b*8 +: 8];
						end
					end
					if (mask == '1) begin
						modelWritten[address] = 1'b1;
					end
				end
				opRead: begin
					expData.push_back(modelMemory[address]);
					expKnown.push_back(modelWritten[address]);
					expCycle.push_back(edgeIndex + 2);
				end
				opCopy: begin
					modelMemory[address] = modelMemory[source];
					modelWritten[address] = modelWritten[source];
					busyAt[edgeIndex] = 1'b1;
				end
				default: begin
					errorAt[edgeIndex] = 1'b1;
				end
			endcase
		end
	endtask

	task automatic idleCycle();
		@(negedge clk0);
		cmdStrobe = 1'b0;
	endtask

	// Outputs settle after the rising edge, so look at them on the falling one
	always @(negedge clk0) begin
		if (rstN) begin
			checkValue("assertion failures",
				32'(scratchpadTop_inst.scratchpadProps_inst.failCount), 32'd0);
			checkValue("busy", 32'(busy), 32'(busyAt.exists(cycleCount)));
			checkValue("cmdError", 32'(cmdError), 32'(errorAt.exists(cycleCount)));
			if (rspValid && expCycle.size() == 0) begin
				checkValue("rspValid", 32'd1, 32'd0);
			end else if (rspValid) begin
				checkValue("rspValid cycle", cycleCount, expCycle[0]);
				if (expKnown[0]) begin
					checkValue("rspData", rspData, expData[0]);
				end
				void'(expData.pop_front());
				void'(expKnown.pop_front());
				void'(expCycle.pop_front());
			end else if (expCycle.size() > 0 && expCycle[0] <= cycleCount) begin
				checkValue("rspValid", 32'd0, 32'd1);
			end
		end
	end

	initial begin
		#(watchdogCycles * clockPeriod);
		$display("Timeout: the run did not finish within %0d cycles", watchdogCycles);
		$display("test failed");
		$fatal(1, "Watchdog expired");
	end

	initial begin
		rstN = 1'b0;
		cmdStrobe = 1'b0;
		cmdOpcode = opWrite;
		cmdAddress = '0;
		cmdSourceAddress = '0;
		cmdData = '0;
		cmdMask = '0;
		repeat (resetCycles) @(posedge clk0);
		@(negedge clk0);
		rstN = 1'b1;

		// Fill every word, then read all of them back
		for (int a = 0; a < depth; a++) begin
			randomWord = nextRandom();
			sendCommand(opWrite, addressSize'(a), '0, randomWord, '1);
		end
		for (int a = 0; a < depth; a++) begin
			sendCommand(opRead, addressSize'(a), '0, '0, '0);
		end

		// Partial masks
		for (int i = 0; i < maskRounds; i++) begin
			randomWord = nextRandom();
			dataWord = nextRandom();
			sendCommand(opWrite, randomWord[addressSize-1:0], '0, dataWord,
				randomWord[byteCount+7:8]);
			sendCommand(opRead, randomWord[addressSize-1:0], '0, '0, '0);
		end

		for (int i = 0; i < copyRounds; i++) begin
			randomWord = nextRandom();
			sendCommand(opCopy, randomWord[addressSize-1:0], randomWord[addressSize+15:16],
				'0, '0);
			idleCycle();
			sendCommand(opRead, randomWord[addressSize-1:0], '0, '0, '0);
		end

		// Back to back on four addresses for read-after-write cases
		for (int i = 0; i < mixedCount; i++) begin
			randomWord = nextRandom();
			dataWord = nextRandom();
			sendCommand(randomWord[4] ? opRead : opWrite, addressSize'(randomWord[1:0]), '0,
				dataWord, randomWord[byteCount+7:8]);
		end

		// Strobe during busy, then a reserved opcode
		for (int i = 0; i < busyRounds; i++) begin
			randomWord = nextRandom();
			dataWord = nextRandom();
			sendCommand(opCopy, randomWord[addressSize-1:0], randomWord[addressSize+7:8],
				'0, '0);
			sendCommand(opWrite, randomWord[addressSize+15:16], '0, dataWord, '1);
			sendCommand(opReserved, randomWord[addressSize+15:16], '0, dataWord, '1);
			sendCommand(opRead, randomWord[addressSize+15:16], '0, '0, '0);
			sendCommand(opRead, randomWord[addressSize-1:0], '0, '0, '0);
		end

		idleCycle();
		while (expCycle.size() != 0) begin
			@(negedge clk0);
		end
		repeat (4) @(negedge clk0);
		if (errorCount == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
logic/memGeomPkg.sv
logic/scratchCmdPkg.sv
logic/cmdDecode.sv
logic/scratchExecute.sv
logic/dualPortSram.sv
logic/readResult.sv
logic/scratchpadTop.sv
verif/scratchpad_props.sv
verif/scratchpadTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= scratchpadTb
FILELIST ?= build.f
OBJDIR ?= obj_dir
VFLAGS ?= --binary --timing --assert --timescale 1ns/10ps
PASS_TEXT ?= test passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
BINARY := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)

run: $(BINARY)
	@out="$$($(abspath $(BINARY)))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJDIR)
